// File: bench/clock_gen.sv
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/video_properties.sv
////////////////////////////////////////
// Wishbone handshake assertions
////////////////////////////////////////
`timescale 1ns/100ps

module video_properties (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    // Ack lasts exactly one cycle
    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    ) else $error("wb_ack held longer than one cycle");

    // Ack only follows a strobed cycle
    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (rst) $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack raised without cyc and stb");

    a_ack_reset: assert property (
        @(posedge clk) rst |=> !wb_ack
    ) else $error("wb_ack high after reset");

endmodule

// File: bench/video_tb.sv
////////////////////////////////////////
// Video block testbench
////////////////////////////////////////
`timescale 1ns/100ps
`include "video_defs.svh"

module video_tb;

    logic        clk, rst, cen6, lhbl, lvbl;
    logic [7:0]  h, v;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [11:0] wb_adr;
    logic [15:0] wb_dat_w, wb_dat_r;
    logic [3:0]  red, green, blue;
    logic [3:0]  map_m [`NUM_LAYERS][256];
    logic [7:0]  sx [`NUM_LAYERS];
    logic [7:0]  sy [`NUM_LAYERS];
    logic [11:0] pal_m [64];
    logic [11:0] exp_q [$];
    logic        val_q [$];
    logic [11:0] cur_exp;
    logic        cur_valid;
    logic        chk_on;
    logic        half_rate;
    logic [15:0] rd;
    logic [11:0] px;
    integer      seed;
    int          err_count;
    int          timeout_count;

    bind video_bus video_properties u_props (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
    );

    clock_gen u_clk (.clk(clk), .rst(rst));

    video_top UUT (
        .clk(clk), .rst(rst), .cen6(cen6), .h(h), .v(v), .lhbl(lhbl), .lvbl(lvbl),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .red(red), .green(green), .blue(blue)
    );

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    endtask

    // Expected RGB by priority, scroll and blanking rules
    function automatic logic [11:0] expected_rgb(input logic [7:0] hh, input logic [7:0] vv,
                                                 input logic hb, input logic vb);
        logic [7:0] ph;
        logic [7:0] pv;
        logic [3:0] c;
        logic [5:0] idx;
        logic       found;
        idx = 6'(`NUM_LAYERS * 16);
        found = 1'b0;
        for (int l = 0; l < `NUM_LAYERS; l++) begin
            ph = hh + sx[l];
            pv = vv + sy[l];
            c = map_m[l][{pv[6:3], ph[6:3]}];
            if (!found && c != 4'h0) begin
                found = 1'b1;
                idx = 6'(l * 16) + 6'(c);
            end
        end
        if (!hb || !vb)
            return 12'h000;
        return pal_m[idx];
    endfunction

    // Rgb holds the pixel of three enables back
    always @(posedge clk) begin
        if (cur_valid)
            check("rgb", {4'h0, red, green, blue}, {4'h0, cur_exp});
        if (rst) begin
            exp_q.delete();
            val_q.delete();
            cur_valid = 1'b0;
        end else if (cen6) begin
            exp_q.push_back(expected_rgb(h, v, lhbl, lvbl));
            val_q.push_back(chk_on);
            if (exp_q.size() > 2) begin
                cur_exp = exp_q.pop_front();
                cur_valid = val_q.pop_front();
            end
        end
    end

    task automatic wait_ack();
        int n;
        n = 0;
        @(posedge clk);
        #1;
        while (!wb_ack && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!wb_ack) begin
            timeout_count++;
            $display("timeout: no wb_ack for address %h", wb_adr);
        end
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [15:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= dat;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [15:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        dat = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic set_tile(input int l, input int idx, input logic [3:0] c);
        wb_write({3'(l), 1'b0, 8'(idx)}, {12'h000, c});
        map_m[l][idx] = c;
    endtask

    task automatic set_scroll(input int l, input logic [7:0] x, input logic [7:0] y);
        wb_write({3'(l), 9'h100}, {8'h00, x});
        wb_write({3'(l), 9'h101}, {8'h00, y});
        sx[l] = x;
        sy[l] = y;
    endtask

    task automatic set_pal(input int i, input logic [11:0] c);
        wb_write({3'd7, 3'd0, 6'(i)}, {4'h0, c});
        pal_m[i] = c;
    endtask

    task automatic put_pixel(input logic [7:0] hh, input logic [7:0] vv,
                             input logic hb, input logic vb);
        @(posedge clk);
        h <= hh;
        v <= vv;
        lhbl <= hb;
        lvbl <= vb;
        cen6 <= 1'b1;
        if (half_rate) begin
            @(posedge clk);
            cen6 <= 1'b0;
        end
    endtask

    // Hold one unblanked pixel until its RGB has left the pipeline
    task automatic probe_pixel(input logic [7:0] hh, input logic [7:0] vv,
                               output logic [11:0] pix_rgb);
        repeat (3) put_pixel(hh, vv, 1'b1, 1'b1);
        @(posedge clk);
        #1;
        pix_rgb = {red, green, blue};
    endtask

    task automatic set_check(input logic on);
        @(posedge clk);
        chk_on <= on;
        // Let pending pixels leave the pipeline
        repeat (4) put_pixel(8'h00, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic sweep(input int vstep);
        for (int vv = 0; vv < 256; vv += vstep)
            for (int hh = 0; hh < 256; hh++)
                put_pixel(8'(hh), 8'(vv), hh < 240, vv < 224);
    endtask

    initial begin
        seed = 32'h6acb;
        err_count = 0;
        timeout_count = 0;
        cur_valid = 1'b0;
        half_rate = 1'b0;
        chk_on <= 1'b1;
        cen6 <= 1'b1;
        h <= 8'h00;
        v <= 8'h00;
        lhbl <= 1'b0;
        lvbl <= 1'b0;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        wb_adr <= 12'h000;
        wb_dat_w <= 16'h0000;
        for (int n = 0; rst !== 1'b0 && n <= 20; n++) begin
            @(posedge clk);
            #1;
            check("wb_ack", {15'h0, wb_ack}, 16'h0000);
            check("rgb", {4'h0, red, green, blue}, 16'h0000);
        end
        if (rst !== 1'b0) begin
            timeout_count++;
            $display("timeout: reset never released");
        end
        repeat (6) put_pixel(8'h10, 8'h10, 1'b0, 1'b1);
        set_check(1'b0);
        // Random RAM fill
        for (int l = 0; l < `NUM_LAYERS; l++) begin
            for (int i = 0; i < 256; i++)
                set_tile(l, i, 4'($random(seed)));
            set_scroll(l, 8'h00, 8'h00);
        end
        for (int i = 0; i < 64; i++)
            set_pal(i, 12'($random(seed)));
        // Read back all kinds of targets
        for (int l = 0; l < `NUM_LAYERS; l++) begin
            set_scroll(l, 8'($random(seed)), 8'($random(seed)));
            wb_read({3'(l), 9'h100}, rd);
            check("scroll_x", rd, {8'h00, sx[l]});
            wb_read({3'(l), 9'h101}, rd);
            check("scroll_y", rd, {8'h00, sy[l]});
            for (int i = 0; i < 256; i += 37) begin
                wb_read({3'(l), 1'b0, 8'(i)}, rd);
                check("tile_map", rd, {12'h000, map_m[l][i]});
            end
        end
        for (int i = 0; i < 64; i += 7) begin
            wb_read({3'd7, 3'd0, 6'(i)}, rd);
            check("palette", rd, {4'h0, pal_m[i]});
        end
        wb_write(12'h600, 16'h00ff);
        wb_read(12'h600, rd);
        check("unmapped", rd, 16'h0000);
        // Priority at fixed tiles
        for (int l = 0; l < `NUM_LAYERS; l++) begin
            set_scroll(l, 8'h00, 8'h00);
            set_tile(l, 2, 4'h0);
        end
        set_tile(0, 0, 4'h5);
        set_tile(1, 0, 4'h7);
        set_tile(0, 1, 4'h0);
        set_tile(1, 1, 4'h9);
        set_check(1'b1);
        for (int hh = 0; hh < 24; hh++)
            put_pixel(8'(hh), 8'h00, 1'b1, 1'b1);
        probe_pixel(8'd0, 8'd0, px);
        check("prio_front", {4'h0, px}, {4'h0, pal_m[5]});
        probe_pixel(8'd8, 8'd0, px);
        check("prio_next", {4'h0, px}, {4'h0, pal_m[25]});
        probe_pixel(8'd16, 8'd0, px);
        check("prio_none", {4'h0, px}, {4'h0, pal_m[48]});
        set_check(1'b0);
        // Scrolled raster sweep
        for (int l = 0; l < `NUM_LAYERS; l++)
            set_scroll(l, 8'($random(seed)), 8'($random(seed)));
        set_check(1'b1);
        sweep(5);
        // Enable on every other cycle
        half_rate = 1'b1;
        sweep(17);
        half_rate = 1'b0;
        set_check(1'b0);
        finish_run();
    end

endmodule

// File: logic/color_mix.sv
////////////////////////////////////////
// Color mixer
// Layer priority, palette and blanking
////////////////////////////////////////
`timescale 1ns/100ps
`include "video_defs.svh"

module color_mix (
    input                            clk,
    input                            rst,
    input                            cen6,
    input                            lhbl,
    input                            lvbl,
    input  video_pkg::layer_codes_t  codes,
    // Palette CPU port
    input                            pal_we,
    input        [`PAL_ADR_W-1:0]    pal_addr,
    input        [`RGB_W-1:0]        pal_wdata,
    output logic [`RGB_W-1:0]        pal_rdata,
    // Video out
    output logic [3:0]               red,
    output logic [3:0]               green,
    output logic [3:0]               blue
);

    import video_pkg::*;

    logic [`RGB_W-1:0]      pal_mem [1 << `PAL_ADR_W];
    logic [1:0]             hbl_dly;
    logic [1:0]             vbl_dly;
    layer_idx_t             sel_layer;
    pix_code_t              sel_code;
    logic [`PAL_ADR_W-1:0]  pal_idx;
    logic [`RGB_W-1:0]      rgb;

    // Palette RAM, CPU side
    always_ff @(posedge clk) begin
        if (pal_we)
            pal_mem[pal_addr] <= pal_wdata;
    end

    assign pal_rdata = pal_mem[pal_addr];

    // Blank flags follow the two layer stages
    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_dly <= 2'b00;
            vbl_dly <= 2'b00;
        end else if (cen6) begin
            hbl_dly <= {hbl_dly[0], lhbl};
            vbl_dly <= {vbl_dly[0], lvbl};
        end
    end

    // Lowest numbered opaque layer wins
    always_comb begin
        sel_layer = layer_idx_t'(`NUM_LAYERS);
        sel_code  = '0;
        for (int i = `NUM_LAYERS - 1; i >= 0; i--) begin
            if (codes[i] != '0) begin
                sel_layer = layer_idx_t'(i);
                sel_code  = codes[i];
            end
        end
    end

    assign pal_idx = {sel_layer, sel_code};

    // Stage 3, palette lookup with blanking
    always_ff @(posedge clk) begin
        if (rst)
            rgb <= '0;
        else if (cen6)
            rgb <= (hbl_dly[1] && vbl_dly[1]) ? pal_mem[pal_idx] : '0;
    end

    assign red   = rgb[`RGB_W-1 -: 4];
    assign green = rgb[7:4];
    assign blue  = rgb[3:0];

endmodule

// File: logic/layer_bus_if.sv
////////////////////////////////////////
// Layer bus
// CPU access to one layer's RAM
////////////////////////////////////////
`timescale 1ns/100ps
`include "video_defs.svh"

interface layer_bus_if;

    logic                 we;
    logic [8:0]           addr;
    logic [`WB_DAT_W-1:0] wdata;
    // Combinational read from the layer RAM
    logic [7:0]           rdata;

    modport bus (
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport layer (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: logic/tile_layer.sv
////////////////////////////////////////
// Tile layer
// Scrolled 16x16 tile map to color code
////////////////////////////////////////
`timescale 1ns/100ps
`include "video_defs.svh"

module tile_layer (
    input                          clk,
    input                          rst,
    input                          cen6,
    input        [7:0]             h,
    input        [7:0]             v,
    // CPU side of the map and scroll registers
    layer_bus_if.layer             cpu,
    // Pixel code for the mixer
    output video_pkg::pix_code_t   code
);

    import video_pkg::*;

    localparam int MAP_AW    = 2 * `MAP_BITS;
    localparam int MAP_DEPTH = 1 << MAP_AW;

    pix_code_t          map_mem [MAP_DEPTH];
    logic [7:0]         scroll_x;
    logic [7:0]         scroll_y;
    logic [7:0]         sum_h;
    logic [7:0]         sum_v;
    logic [MAP_AW-1:0]  tile_addr;

    // CPU writes to the tile map
    always_ff @(posedge clk) begin
        if (cpu.we && !cpu.addr[8])
            map_mem[cpu.addr[MAP_AW-1:0]] <= cpu.wdata[3:0];
    end

    // Scroll registers at adr[8]=1
    always_ff @(posedge clk) begin
        if (rst) begin
            scroll_x <= 8'h00;
            scroll_y <= 8'h00;
        end else if (cpu.we && cpu.addr[8]) begin
            if (cpu.addr[0])
                scroll_y <= cpu.wdata[7:0];
            else
                scroll_x <= cpu.wdata[7:0];
        end
    end

    always_comb begin
        if (cpu.addr[8])
            cpu.rdata = cpu.addr[0] ? scroll_y : scroll_x;
        else
            cpu.rdata = {4'h0, map_mem[cpu.addr[MAP_AW-1:0]]};
    end

    // Scrolled beam position
    assign sum_h = h + scroll_x;
    assign sum_v = v + scroll_y;

    // Stage 1, tile address, bit 7 dropped so the map wraps at 128
    always_ff @(posedge clk) begin
        if (rst)
            tile_addr <= '0;
        else if (cen6)
            tile_addr <= {sum_v[`MAP_BITS+2:3], sum_h[`MAP_BITS+2:3]};
    end

    // Stage 2, map read
    always_ff @(posedge clk) begin
        if (rst)
            code <= '0;
        else if (cen6)
            code <= map_mem[tile_addr];
    end

endmodule

// File: logic/video_bus.sv
////////////////////////////////////////
// Video bus
// Wishbone slave for layer RAM and palette
////////////////////////////////////////
`timescale 1ns/100ps
`include "video_defs.svh"

module video_bus (
    input                        clk,
    input                        rst,
    // Wishbone classic slave
    input                        wb_cyc,
    input                        wb_stb,
    input                        wb_we,
    input        [`WB_ADR_W-1:0] wb_adr,
    input        [`WB_DAT_W-1:0] wb_dat_w,
    output logic [`WB_DAT_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    // Layer RAM ports
    layer_bus_if.bus             lyr [`NUM_LAYERS],
    // Palette port
    output logic                 pal_we,
    output logic [`PAL_ADR_W-1:0] pal_addr,
    output logic [`RGB_W-1:0]    pal_wdata,
    input        [`RGB_W-1:0]    pal_rdata
);

    import video_pkg::*;

    bus_state_e           state;
    target_e              target;
    layer_idx_t           lyr_sel;
    logic [2:0]           tgt_field;
    logic                 access;
    logic                 wr_start;
    logic [7:0]           lyr_rdata [`NUM_LAYERS];
    logic [`WB_DAT_W-1:0] rd_data;

    // Target select from the top address bits
    assign tgt_field = wb_adr[11:9];
    assign lyr_sel   = wb_adr[10:9];

    always_comb begin
        if (tgt_field < 3'(`NUM_LAYERS))
            target = TGT_LAYER;
        else if (tgt_field == 3'd7)
            target = TGT_PALETTE;
        else
            target = TGT_NONE;
    end

    // New access only while ack is low
    assign access   = (state == BUS_IDLE) && wb_cyc && wb_stb;
    assign wr_start = access && wb_we;

    for (genvar i = 0; i < `NUM_LAYERS; i++) begin : g_lyr
        assign lyr[i].we    = wr_start && (target == TGT_LAYER) &&
                              (lyr_sel == layer_idx_t'(i));
        assign lyr[i].addr  = wb_adr[8:0];
        assign lyr[i].wdata = wb_dat_w;
        assign lyr_rdata[i] = lyr[i].rdata;
    end

    assign pal_we    = wr_start && (target == TGT_PALETTE);
    assign pal_addr  = wb_adr[`PAL_ADR_W-1:0];
    assign pal_wdata = wb_dat_w[`RGB_W-1:0];

    // Read mux, unmapped space reads 0
    always_comb begin
        case (target)
            TGT_LAYER:   rd_data = {8'h00, lyr_rdata[lyr_sel]};
            TGT_PALETTE: rd_data = {{(`WB_DAT_W-`RGB_W){1'b0}}, pal_rdata};
            default:     rd_data = '0;
        endcase
    end

    // Fixed single wait state
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: if (access) state <= BUS_ACK;
                BUS_ACK:  state <= BUS_IDLE;
                default:  state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            wb_dat_r <= rd_data;
    end

    assign wb_ack = (state == BUS_ACK);

endmodule

// File: logic/video_defs.svh
////////////////////////////////////////
// Video block sizes and bus widths
////////////////////////////////////////
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Tile layers, layer 0 in front
`define NUM_LAYERS 3

// Tile map index bits per axis, 16x16 tiles of 8x8 pixels
`define MAP_BITS 4

// Wishbone word address and data widths
`define WB_ADR_W 12
`define WB_DAT_W 16

// Palette entry, 4 bits per gun
`define RGB_W 12
`define PAL_ADR_W 6

`endif

// File: logic/video_pkg.sv
////////////////////////////////////////
// Video package
// Pixel, layer and bus types
////////////////////////////////////////
`include "video_defs.svh"

package video_pkg;

    // Tile color code, 0 is transparent
    typedef logic [3:0] pix_code_t;

    // Layer number, also the high palette address bits
    typedef logic [1:0] layer_idx_t;

    // One code per layer, layers to mixer
    typedef pix_code_t [`NUM_LAYERS-1:0] layer_codes_t;

    // Wishbone slave states
    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_e;

    // Decoded access target
    typedef enum logic [1:0] {
        TGT_LAYER,
        TGT_PALETTE,
        TGT_NONE
    } target_e;

endpackage

// File: logic/video_top.sv
////////////////////////////////////////
// Video top
// Tile layers, bus decoder and mixer
////////////////////////////////////////
`timescale 1ns/100ps
`include "video_defs.svh"

module video_top (
    input                        clk,
    input                        rst,
    input                        cen6,
    // Beam position and blanking
    input        [7:0]           h,
    input        [7:0]           v,
    input                        lhbl,
    input                        lvbl,
    // Wishbone from the CPU
    input                        wb_cyc,
    input                        wb_stb,
    input                        wb_we,
    input        [`WB_ADR_W-1:0] wb_adr,
    input        [`WB_DAT_W-1:0] wb_dat_w,
    output logic [`WB_DAT_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    // RGB out
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue
);

    import video_pkg::*;

    layer_codes_t            codes;
    logic                    pal_we;
    logic [`PAL_ADR_W-1:0]   pal_addr;
    logic [`RGB_W-1:0]       pal_wdata;
    logic [`RGB_W-1:0]       pal_rdata;

    layer_bus_if lyr_if [`NUM_LAYERS] ();

    video_bus u_bus (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .wb_cyc     ( wb_cyc     ),
        .wb_stb     ( wb_stb     ),
        .wb_we      ( wb_we      ),
        .wb_adr     ( wb_adr     ),
        .wb_dat_w   ( wb_dat_w   ),
        .wb_dat_r   ( wb_dat_r   ),
        .wb_ack     ( wb_ack     ),
        .lyr        ( lyr_if     ),
        .pal_we     ( pal_we     ),
        .pal_addr   ( pal_addr   ),
        .pal_wdata  ( pal_wdata  ),
        .pal_rdata  ( pal_rdata  )
    );

    // One tile layer per slot, layer 0 in front
    for (genvar i = 0; i < `NUM_LAYERS; i++) begin : g_layer
        tile_layer u_layer (
            .clk    ( clk       ),
            .rst    ( rst       ),
            .cen6   ( cen6      ),
            .h      ( h         ),
            .v      ( v         ),
            .cpu    ( lyr_if[i] ),
            .code   ( codes[i]  )
        );
    end

    color_mix u_mix (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen6       ( cen6       ),
        .lhbl       ( lhbl       ),
        .lvbl       ( lvbl       ),
        .codes      ( codes      ),
        .pal_we     ( pal_we     ),
        .pal_addr   ( pal_addr   ),
        .pal_wdata  ( pal_wdata  ),
        .pal_rdata  ( pal_rdata  ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       )
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the video block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module video_tb -Mdir obj_dir

./obj_dir/Vvideo_tb > sim.log 2>&1 || true
cat sim.log

grep -q ">>> PASS" sim.log

// File: sim.f
+incdir+logic
logic/video_pkg.sv
logic/layer_bus_if.sv
logic/video_bus.sv
logic/tile_layer.sv
logic/color_mix.sv
logic/video_top.sv
bench/clock_gen.sv
bench/video_properties.sv
bench/video_tb.sv
